// ==== Makefile ====
# Verilator build and run for the dictionary search project

VERILATOR ?= verilator
TOP       ?= dict_search_tb
RTL_TOP   ?= dict_search_top
FILELIST  ?= verilog.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0
LINTFLAGS ?= --lint-only -Wall
RTL_SRCS  ?= hdl/forth_pkg.sv hdl/byte_ram.sv hdl/word_finder.sv hdl/dict_search_top.sv
PASS_MSG  ?= === PASS ===

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR) -o $(TOP)

run: build
	@out="$$(./$(BUILD_DIR)/$(TOP) 2>&1)"; echo "$$out"; \
	echo "$$out" | grep -qF -- "$(PASS_MSG)"

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(RTL_TOP) $(RTL_SRCS)

clean:
	rm -rf $(BUILD_DIR)

// ==== hdl/byte_ram.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// simple dual-port byte RAM
// host write port, registered read port
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`default_nettype none

module byte_ram (
    input  logic                         clk,
    input  forth_pkg::mem_wr_t           wr,        // host byte write
    input  logic [forth_pkg::ADDR_W-1:0] rd_addr,   // finder read address
    output logic [7:0]                   rd_data    // byte at last cycle's rd_addr
);
    import forth_pkg::*;

    logic [7:0] mem [MEM_DEPTH];                    // dictionary storage

    // write port, takes effect at the edge
    always_ff @(posedge clk) begin
        if (wr.en) begin
            mem[wr.addr] <= wr.data;                // host load
        end
    end

    // read port, one cycle latency
    // same-address write in the same cycle gives the old byte
    always_ff @(posedge clk) begin
        rd_data <= mem[rd_addr];                    // registered read
    end

endmodule

`default_nettype wire

// ==== hdl/dict_search_top.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// dictionary search top level
// byte RAM joined to the word finder
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`default_nettype none

module dict_search_top (
    input  logic                    clk,
    input  logic                    reset,
    input  forth_pkg::mem_wr_t      wr,             // host load port
    input  logic                    start,          // search strobe
    input  forth_pkg::find_req_t    req,            // latest and string address
    output logic                    busy,
    output logic                    done,
    output forth_pkg::find_result_t result
);
    import forth_pkg::*;

    logic [ADDR_W-1:0] rd_addr;                     // finder to RAM
    logic [7:0]        rd_data;                     // RAM to finder

    // dictionary and string storage
    byte_ram ram_i (
        .clk     (clk),
        .wr      (wr),
        .rd_addr (rd_addr),
        .rd_data (rd_data)
    );

    // owns the single read port
    word_finder finder_i (
        .clk     (clk),
        .reset   (reset),
        .start   (start),
        .req     (req),
        .rd_addr (rd_addr),
        .rd_data (rd_data),
        .busy    (busy),
        .done    (done),
        .result  (result)
    );

endmodule

`default_nettype wire

// ==== hdl/forth_pkg.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// dictionary search shared parameters
// finder state enum, host and result structs
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`default_nettype none

package forth_pkg;

    localparam int ADDR_W    = 12;                  // byte address width
    localparam int MEM_DEPTH = 4096;                // bytes of dictionary space
    localparam int LINK_W    = 16;                  // stored link, two bytes

    localparam logic [LINK_W-1:0] NULL_LINK     = 16'hffff; // end of chain
    localparam logic [7:0]        NAME_LEN_MASK = 8'h1f;    // length bits of count byte

    // one host byte write
    typedef struct packed {
        logic              en;                      // write strobe
        logic [ADDR_W-1:0] addr;                    // byte address
        logic [7:0]        data;                    // byte to store
    } mem_wr_t;

    // search request, sampled with start
    typedef struct packed {
        logic [LINK_W-1:0] latest;                  // newest entry, link format
        logic [ADDR_W-1:0] tib_addr;                // counted search string
    } find_req_t;

    // search outcome, held until next start
    typedef struct packed {
        logic              hit;                     // name found
        logic [ADDR_W-1:0] pfa;                     // byte after name, zero on miss
    } find_result_t;

    // finder FSM, one cycle per state
    typedef enum logic [3:0] {
        IDLE,                                       // wait for start
        LINK_LO,                                    // read link low byte
        LINK_HI,                                    // read link high byte
        NAME_LEN,                                   // read entry count byte
        TIB_LEN,                                    // read string count byte
        LEN_CMP,                                    // compare masked lengths
        NAME_CH,                                    // read name char
        TIB_CH,                                     // read string char
        CH_CMP                                      // compare chars
    } finder_state_t;

endpackage

`default_nettype wire

// ==== hdl/word_finder.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// dictionary walk and name compare FSM
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`default_nettype none

module word_finder (
    input  logic                         clk,
    input  logic                         reset,
    input  logic                         start,     // search strobe
    input  forth_pkg::find_req_t         req,       // valid with start
    output logic [forth_pkg::ADDR_W-1:0] rd_addr,   // RAM read address
    input  logic [7:0]                   rd_data,   // RAM byte one cycle late
    output logic                         busy,      // search in progress
    output logic                         done,      // one cycle at end
    output forth_pkg::find_result_t      result     // hit and pfa
);
    import forth_pkg::*;

    finder_state_t     state;
    finder_state_t     next_state;
    logic [ADDR_W-1:0] entry_addr;                  // link field of current entry
    logic [ADDR_W-1:0] tib_addr;                    // base of counted string
    logic [LINK_W-1:0] link;                        // link of current entry
    logic [7:0]        target_len;                  // masked name length
    logic [7:0]        remaining;                   // chars left to compare
    logic [ADDR_W-1:0] name_ptr;                    // next name char
    logic [ADDR_W-1:0] str_ptr;                     // next string char
    logic [ADDR_W-1:0] pfa;                         // candidate pfa
    logic [ADDR_W-1:0] pfa_calc;                    // first name byte plus length
    logic [7:0]        name_ch;                     // captured name char
    logic [7:0]        cnt_len;                     // masked count of rd_data
    logic              len_eq;
    logic              ch_eq;
    logic              last_link;                   // no older entry
    logic              accept;                      // start taken in IDLE
    logic              finish;                      // search ends this cycle
    logic              match;                       // name found this cycle
    logic              follow;                      // move to older entry

    assign cnt_len   = rd_data & NAME_LEN_MASK;     // flags dropped
    assign len_eq    = (cnt_len == target_len);     // valid in LEN_CMP
    assign ch_eq     = (rd_data == name_ch);        // valid in CH_CMP
    assign last_link = (link == NULL_LINK);
    assign accept    = (state == IDLE) && start;
    assign pfa_calc  = name_ptr + ADDR_W'(target_len);

    // read address from state alone
    always_comb begin
        case (state)
            LINK_HI:  rd_addr = entry_addr + ADDR_W'(1);  // link high byte
            NAME_LEN: rd_addr = entry_addr + ADDR_W'(2);  // count byte
            TIB_LEN:  rd_addr = tib_addr;                 // string count
            TIB_CH:   rd_addr = str_ptr;                  // string char
            LEN_CMP,
            NAME_CH,
            CH_CMP:   rd_addr = name_ptr;                 // name char
            default:  rd_addr = entry_addr;               // link low byte
        endcase
    end

    // next state and end of search
    always_comb begin
        next_state = state;
        match      = 1'b0;
        finish     = 1'b0;
        follow     = 1'b0;
        case (state)
            IDLE: begin
                if (start) next_state = LINK_LO;
            end
            LINK_LO: begin
                if (last_link) finish = 1'b1;       // empty dictionary
                else next_state = LINK_HI;
            end
            LINK_HI:  next_state = NAME_LEN;
            NAME_LEN: next_state = TIB_LEN;
            TIB_LEN:  next_state = LEN_CMP;
            LEN_CMP: begin
                if (len_eq && target_len == 8'd0) begin
                    match = 1'b1;                   // empty names match
                end else if (len_eq) begin
                    next_state = NAME_CH;
                end else if (last_link) begin
                    finish = 1'b1;                  // oldest entry means a miss
                end else begin
                    follow     = 1'b1;
                    next_state = LINK_LO;
                end
            end
            NAME_CH: next_state = TIB_CH;
            TIB_CH:  next_state = CH_CMP;
            CH_CMP: begin
                if (ch_eq && remaining == 8'd1) begin
                    match = 1'b1;                   // last char equal
                end else if (ch_eq) begin
                    next_state = NAME_CH;
                end else if (last_link) begin
                    finish = 1'b1;
                end else begin
                    follow     = 1'b1;
                    next_state = LINK_LO;
                end
            end
            default: next_state = IDLE;
        endcase
        if (match) finish = 1'b1;
        if (finish) next_state = IDLE;
    end

    // control state
    always_ff @(posedge clk) begin
        if (reset) begin
            state  <= IDLE;
            busy   <= 1'b0;
            done   <= 1'b0;
            result <= '0;
        end else begin
            state <= next_state;
            done  <= finish;                        // single pulse
            if (accept) begin
                busy   <= 1'b1;
                result <= '0;                       // miss unless matched
            end else if (finish) begin
                busy <= 1'b0;                       // falls with done
            end
            if (match) begin
                result.hit <= 1'b1;
                result.pfa <= (state == LEN_CMP) ? pfa_calc : pfa;
            end
        end
    end

    // walk registers
    always_ff @(posedge clk) begin
        case (state)
            IDLE: begin
                if (start) begin
                    entry_addr <= req.latest[ADDR_W-1:0];
                    link       <= req.latest;       // checked in LINK_LO
                    tib_addr   <= req.tib_addr;
                end
            end
            LINK_HI:  link[7:0] <= rd_data;         // low link byte arrives
            NAME_LEN: begin
                link[LINK_W-1:8] <= rd_data;        // high link byte
                name_ptr         <= entry_addr + ADDR_W'(3);
            end
            TIB_LEN: begin
                target_len <= cnt_len;              // entry count byte
                str_ptr    <= tib_addr + ADDR_W'(1);
            end
            LEN_CMP: begin
                remaining <= target_len;
                pfa       <= pfa_calc;
            end
            TIB_CH: name_ch <= rd_data;             // name char arrives
            CH_CMP: begin
                if (ch_eq) begin
                    remaining <= remaining - 8'd1;
                    name_ptr  <= name_ptr + ADDR_W'(1);
                    str_ptr   <= str_ptr + ADDR_W'(1);
                end
            end
            default: ;
        endcase
        if (follow) begin
            entry_addr <= link[ADDR_W-1:0];         // truncated link
        end
    end

endmodule

`default_nettype wire

// ==== test/dict_search_checker.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// strobe and busy protocol assertions
// bound to the dictionary search top
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`default_nettype none

module dict_search_checker (
    input logic               clk,
    input logic               reset,
    input forth_pkg::mem_wr_t wr,                   // host load port
    input logic               start,
    input logic               busy,
    input logic               done
);
    // done is a single-cycle pulse
    done_one_cycle: assert property (@(posedge clk) disable iff (reset)
        done |=> !done)
        else $error("done stayed high for more than one cycle");

    // done marks the cycle where busy has just fallen
    done_with_busy_fall: assert property (@(posedge clk) disable iff (reset)
        done |-> !busy && $past(busy))
        else $error("done not aligned with busy falling");

    // busy only rises after a start seen while idle
    busy_after_start: assert property (@(posedge clk) disable iff (reset)
        $rose(busy) |-> $past(start))
        else $error("busy rose without an accepted start");

    no_write_while_busy: assert property (@(posedge clk) disable iff (reset)
        busy |-> !wr.en)                            // RAM is owned by the walk
        else $error("host wrote memory during a search");

endmodule

bind dict_search_top dict_search_checker checker_i (
    .clk   (clk),
    .reset (reset),
    .wr    (wr),
    .start (start),
    .busy  (busy),
    .done  (done)
);

`default_nettype wire

// ==== test/dict_search_tb.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// dictionary search testbench
// image load, search table, walk model
// compare tasks and watchdog
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`default_nettype none

module dict_search_tb;
    import forth_pkg::*;

    localparam int N_ENTRIES  = 8;
    localparam int N_STRINGS  = 6;
    localparam int N_ROWS     = 8;
    localparam int ENTRY_BASE = 'h100;              // oldest entry
    localparam int ENTRY_STEP = 'h40;
    localparam int STR_BASE   = 'h800;              // counted search strings
    localparam int STR_STEP   = 'h20;

    typedef struct packed {
        find_req_t    req;                          // latest and string address
        logic         restart;                      // second start while busy
        find_result_t exp;                          // filled by the model
    } row_t;

    logic         clk;
    logic         reset;
    mem_wr_t      wr;
    logic         start;
    find_req_t    req;
    logic         busy;
    logic         done;
    find_result_t result;

    logic [7:0] image [MEM_DEPTH];                  // local copy of the RAM
    row_t       rows [N_ROWS];
    find_req_t  decoy;                              // request of the ignored start
    string      names [N_ENTRIES] = '{"DUP", "DROP", "SWAP", "OVER", "ROT", "EMIT", "DUP", "CR"};
    string      strs [N_STRINGS] = '{"DUP", "CR", "DUX", "DRO", "EMIT", "ROT"};

    dict_search_top dict_search_top_i (
        .clk    (clk),
        .reset  (reset),
        .wr     (wr),
        .start  (start),
        .req    (req),
        .busy   (busy),
        .done   (done),
        .result (result)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;                     // 100 ns period
    end

    function automatic int entry_at(input int idx);
        return ENTRY_BASE + idx * ENTRY_STEP;
    endfunction

    // count byte then chars
    function automatic void put_counted(input int addr, input string s, input logic [7:0] flags);
        image[addr] = 8'(s.len()) | flags;
        for (int k = 0; k < s.len(); k++)
            image[addr + 1 + k] = s[k];
    endfunction

    // walk newest to oldest until the first full match
    function automatic find_result_t model_find(input find_req_t q);
        find_result_t      r;
        logic [LINK_W-1:0] lnk;
        int                ea;
        int                len;
        bit                same;
        r   = '0;
        lnk = q.latest;
        while (lnk != NULL_LINK) begin
            ea   = int'(lnk[ADDR_W-1:0]);           // upper link bits ignored
            len  = int'(image[ea + 2] & NAME_LEN_MASK);
            same = (len == int'(image[q.tib_addr] & NAME_LEN_MASK));
            for (int k = 0; k < len; k++)
                if (image[ea + 3 + k] != image[int'(q.tib_addr) + 1 + k]) same = 1'b0;
            if (same) begin
                r.hit = 1'b1;
                r.pfa = ADDR_W'(ea + 3 + len);      // byte after the name
                return r;
            end
            lnk = {image[ea + 1], image[ea]};
        end
        return r;
    endfunction

    task automatic build_image();
        logic [LINK_W-1:0] lnk;
        int                a;
        for (a = 0; a < MEM_DEPTH; a++)
            image[a] = 8'($urandom);                // unused bytes stay random
        for (int i = 0; i < N_ENTRIES; i++) begin
            lnk = (i == 0) ? NULL_LINK : {4'($urandom % 8), 12'(entry_at(i - 1))};
            a = entry_at(i);
            image[a]     = lnk[7:0];                // low byte first
            image[a + 1] = lnk[15:8];
            put_counted(a + 2, names[i], (8'($urandom) & 8'he0) | 8'h80);  // random flags
        end
        for (int i = 0; i < N_STRINGS; i++)
            put_counted(STR_BASE + i * STR_STEP, strs[i], 8'h00);
    endtask

    task automatic set_row(input int i, input logic [LINK_W-1:0] latest, input int s,
                           input logic restart);
        rows[i].req.latest   = latest;
        rows[i].req.tib_addr = ADDR_W'(STR_BASE + s * STR_STEP);
        rows[i].restart      = restart;
        rows[i].exp          = model_find(rows[i].req);
    endtask

    task automatic load_image();
        for (int a = 0; a < MEM_DEPTH; a++) begin
            @(posedge clk);
            wr <= '{en: 1'b1, addr: ADDR_W'(a), data: image[a]};
        end
        @(posedge clk);
        wr <= '0;
    endtask

    task automatic check_result(input find_result_t got, input find_result_t exp,
                                input string what);
        if (got !== exp) begin
            $display("FAIL at %0t ns: %s hit %0b pfa %03h, expected hit %0b pfa %03h",
                     $time, what, got.hit, got.pfa, exp.hit, exp.pfa);
            $display("=== FAIL ===");
            $fatal(1, "result mismatch");
        end
    endtask

    task automatic check_busy(input logic got, input logic exp, input string what);
        if (got !== exp) begin
            $display("FAIL at %0t ns: %s busy %0b, expected %0b", $time, what, got, exp);
            $display("=== FAIL ===");
            $fatal(1, "busy mismatch");
        end
    endtask

    task automatic check_done(input logic got, input logic exp, input string what);
        if (got !== exp) begin
            $display("FAIL at %0t ns: %s done %0b, expected %0b", $time, what, got, exp);
            $display("=== FAIL ===");
            $fatal(1, "done mismatch");
        end
    endtask

    task automatic run_row(input int i);
        @(posedge clk);
        start <= 1'b1;
        req   <= rows[i].req;
        @(posedge clk);
        start <= rows[i].restart;                   // lands while busy
        req   <= rows[i].restart ? decoy : find_req_t'(28'($urandom));
        @(negedge clk);
        check_busy(busy, 1'b1, $sformatf("row %0d after start", i));
        @(posedge clk);
        start <= 1'b0;
        @(negedge clk);
        if (rows[i].req.latest == NULL_LINK)
            check_done(done, 1'b1, $sformatf("row %0d empty dictionary", i));
        while (!done) @(negedge clk);
        check_busy(busy, 1'b0, $sformatf("row %0d at done", i));
        check_result(result, rows[i].exp, $sformatf("row %0d at done", i));
        @(negedge clk);
        check_done(done, 1'b0, $sformatf("row %0d cycle after done", i));
        check_result(result, rows[i].exp, $sformatf("row %0d held", i));
    endtask

    // worst case walk per row plus load time
    initial begin
        int unsigned limit;
        limit = MEM_DEPTH + 20 + N_ROWS * (N_ENTRIES * (5 + 3 * 31) + 20);
        repeat (limit) @(posedge clk);
        $display("timeout: a search never finished within %0d cycles", limit);
        $display("=== FAIL ===");
        $fatal(1, "watchdog expired");
    end

    initial begin
        logic [LINK_W-1:0] newest;
        void'($urandom(32'ha104_bab8));
        reset = 1'b1;
        wr    = '0;
        start = 1'b0;
        req   = '0;
        build_image();
        newest = LINK_W'(entry_at(N_ENTRIES - 1));
        decoy  = '{latest: newest, tib_addr: ADDR_W'(STR_BASE + STR_STEP)};
        set_row(0, newest, 1, 1'b0);                // newest entry
        set_row(1, newest, 0, 1'b0);                // duplicate name returns the newer one
        set_row(2, LINK_W'(entry_at(5)), 0, 1'b0);  // oldest through links
        set_row(3, newest, 2, 1'b0);                // last char differs
        set_row(4, newest, 3, 1'b0);                // prefix of DROP
        set_row(5, newest, 4, 1'b0);
        set_row(6, NULL_LINK, 5, 1'b1);             // empty dictionary
        set_row(7, newest, 5, 1'b1);
        repeat (2) @(posedge clk);
        reset <= 1'b0;
        @(negedge clk);
        check_busy(busy, 1'b0, "after reset");
        check_done(done, 1'b0, "after reset");
        check_result(result, '0, "after reset");
        load_image();
        for (int i = 0; i < N_ROWS; i++)
            run_row(i);
        $display("=== PASS ===");
        $finish;
    end

endmodule

`default_nettype wire

// ==== verilog.f ====
hdl/forth_pkg.sv
hdl/byte_ram.sv
hdl/word_finder.sv
hdl/dict_search_top.sv
test/dict_search_checker.sv
test/dict_search_tb.sv
